// ==== Makefile ====
# Verilator build for the game engine testbench

VERILATOR ?= verilator
TOP       ?= tb_tetris
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== src.f ====
+incdir+verilog
+incdir+tests
verilog/tetris_pkg.sv
verilog/piece_if.sv
verilog/key_decoder.sv
verilog/piece_control.sv
verilog/playfield.sv
verilog/score_keeper.sv
verilog/tetris_core.sv
tests/tb_tetris.sv

// ==== tests/tetris_ref.svh ====
`ifndef TETRIS_REF_SVH
`define TETRIS_REF_SVH

// model of the sequencer, the hold slot and the board
shape_t m_seq [7];
int     m_cnt;
shape_t m_cur;
shape_t m_hold;
cell_t  m_board [`BOARD_COLS][`BOARD_ROWS];

// shift by one, reorder after a full pass of seven
function automatic shape_t next_shape();
    shape_t s [7];
    s = m_seq;
    if (m_cnt == 6) begin
        m_seq[6] = s[3];
        m_seq[5] = s[1];
        m_seq[4] = s[2];
        m_seq[3] = s[6];
        m_seq[2] = s[0];
        m_seq[1] = s[4];
        m_seq[0] = s[5];
        m_cnt    = 0;
    end else begin
        m_seq[0] = s[6];
        for (int k = 1; k < 7; k++) begin
            m_seq[k] = s[k - 1];
        end
        m_cnt++;
    end
    return m_seq[6];
endfunction

function automatic bit model_free(col_t c, row_t r);
    return (c < `BOARD_COLS) && (r < `BOARD_ROWS) && (m_board[c][r] == '0);
endfunction

// lowest row the piece reaches from the top
function automatic int landing_row(shape_t s, col_t x);
    int           y;
    bit           ok;
    piece_cells_t pc;
    y = 0;
    ok = 1'b1;
    while (ok && y < 31) begin
        pc = shape_cells(x, row_t'(y + 1), s, 2'd0);
        for (int k = 0; k < 4; k++) begin
            ok &= model_free(pc[k].col, pc[k].row);
        end
        if (ok) begin
            y++;
        end
    end
    return y;
endfunction

// place the piece and delete full rows, top to bottom
function automatic int drop_model(shape_t s, col_t x);
    piece_cells_t pc;
    int           full;
    bit           row_full;
    full = 0;
    pc = shape_cells(x, row_t'(landing_row(s, x)), s, 2'd0);
    for (int k = 0; k < 4; k++) begin
        m_board[pc[k].col][pc[k].row] = cell_t'(s) + 3'd1;
    end
    for (int r = 0; r < `BOARD_ROWS; r++) begin
        row_full = 1'b1;
        for (int c = 0; c < `BOARD_COLS; c++) begin
            row_full &= (m_board[c][r] != '0);
        end
        if (row_full) begin
            full++;
            for (int c = 0; c < `BOARD_COLS; c++) begin
                for (int rr = r; rr > 0; rr--) begin
                    m_board[c][rr] = m_board[c][rr - 1];
                end
                m_board[c][0] = '0;
            end
        end
    end
    return full;
endfunction

function automatic score_t score_step(int rows);
    case (rows)
        1:       return score_t'(`SCORE_1);
        2:       return score_t'(`SCORE_2);
        3:       return score_t'(`SCORE_3);
        4:       return score_t'(`SCORE_4);
        default: return '0;
    endcase
endfunction

// deepest legal column, ties broken at random
function automatic col_t choose_column(shape_t s);
    col_t         best [$];
    int           best_row;
    int           y;
    bit           ok;
    piece_cells_t pc;
    best_row = -1;
    for (int x = 0; x < `BOARD_COLS; x++) begin
        pc = shape_cells(col_t'(x), '0, s, 2'd0);
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            ok &= (pc[k].col < `BOARD_COLS);
        end
        if (ok) begin
            y = landing_row(s, col_t'(x));
            if (y > best_row) begin
                best.delete();
                best_row = y;
            end
            if (y == best_row) begin
                best.push_back(col_t'(x));
            end
        end
    end
    return best[$urandom % best.size()];
endfunction

`endif

// ==== tests/tb_tetris.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tetris_defines.svh"

module tb_tetris;
    import tetris_pkg::*;

    // slowest piece falls the whole board under plain gravity
    localparam int PIECE_CYCLES   = `BOARD_ROWS * (`FALL_LIMIT + 4) + 4 * `STALL_CYCLES + 200;
    localparam int TIMEOUT_CYCLES = 40 * PIECE_CYCLES;
    localparam col_t SPAWN        = col_t'(`SPAWN_COL);

    logic        i_clk;
    logic        i_rst_n;
    logic        i_start;
    logic        i_stop;
    logic [7:0]  i_key;
    game_state_e o_state;
    logic [2:0]  o_delete;
    logic        o_finish;
    score_t      o_score;

    int          cycle_cnt;
    int          error_count;
    logic [2:0]  exp_rows;
    score_t      exp_score;
    game_state_e prev_state;

    `include "tetris_ref.svh"

    tetris_core tetris_core_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_stop   (i_stop),
        .i_key    (i_key),
        .o_state  (o_state),
        .o_delete (o_delete),
        .o_finish (o_finish),
        .o_score  (o_score)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic stop_on_failure();
        error_count++;
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic check_state(game_state_e got, game_state_e exp);
        if (got !== exp) begin
            report_mismatch($sformatf("state %s, expected %s", got.name(), exp.name()));
        end
    endtask

    task automatic check_rows(logic [2:0] got, logic [2:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("o_delete %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_score(score_t got, score_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("o_score %0d, expected %0d", got, exp));
        end
    endtask

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the game made no progress within %0d cycles", cycle_cnt);
            stop_on_failure();
        end
    end

    // row count and score are checked when a delete state ends
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (prev_state == ST_DELETE && o_state != ST_DELETE) begin
                check_rows(o_delete, exp_rows);
                check_score(o_score, exp_score);
            end else begin
                check_rows(o_delete, 3'd0);
            end
            if (o_finish && o_state != ST_IDLE) begin
                report_mismatch("finish pulse outside idle");
            end
        end
        prev_state = o_state;
    end

    task automatic step();
        @(posedge i_clk);
        #2;
    endtask

    task automatic wait_state(game_state_e s);
        while (o_state != s) begin
            step();
        end
    endtask

    // key stays down until the move shows in the state
    task automatic press(logic [7:0] key, game_state_e target);
        wait_state(ST_WAIT);
        i_key = key;
        do begin
            step();
        end while (o_state != target);
        i_key = 8'h00;
    endtask

    task automatic start_game();
        i_start = 1'b1;
        step();
        i_start = 1'b0;
        for (int c = 0; c < `BOARD_COLS; c++) begin
            for (int r = 0; r < `BOARD_ROWS; r++) begin
                m_board[c][r] = '0;
            end
        end
        m_cnt     = 0;
        m_hold    = 3'd7;
        exp_score = '0;
        check_state(o_state, ST_STALL);
        wait_state(ST_WAIT);
    endtask

    task automatic hold_model();
        shape_t tmp;
        if (m_hold == 3'd7) begin
            tmp = next_shape();
        end else begin
            tmp = m_hold;
        end
        m_hold = m_cur;
        m_cur  = tmp;
    endtask

    // next piece spawns, game over when it cannot fall at all
    task automatic settle(output bit over);
        m_cur = next_shape();
        over  = (landing_row(m_cur, SPAWN) == 0);
        while (o_state != ST_WAIT && o_state != ST_IDLE) begin
            step();
        end
        check_state(o_state, over ? ST_IDLE : ST_WAIT);
        if (over && !o_finish) begin
            report_mismatch("no finish pulse at game over");
        end
    endtask

    task automatic place_piece(col_t x, output bit over);
        int n;
        for (n = `SPAWN_COL; n < int'(x); n++) begin
            press(`KEY_RIGHT, ST_STALL);
        end
        for (n = `SPAWN_COL; n > int'(x); n--) begin
            press(`KEY_LEFT, ST_STALL);
        end
        exp_rows  = 3'(drop_model(m_cur, x));
        exp_score = exp_score + score_step(int'(exp_rows));
        press(`KEY_DOWN, ST_DELETE);
        settle(over);
    endtask

    // counting starts at the first gravity step, one step per row after it
    task automatic fall_piece(logic [7:0] key, output int cycles, output int rows,
                              output bit over);
        rows      = landing_row(m_cur, SPAWN);
        exp_rows  = 3'(drop_model(m_cur, SPAWN));
        exp_score = exp_score + score_step(int'(exp_rows));
        wait_state(ST_WAIT);
        i_key = key;
        wait_state(ST_LAND);
        cycles = 0;
        while (o_state != ST_DELETE) begin
            step();
            cycles++;
        end
        i_key = 8'h00;
        settle(over);
    endtask

    initial begin
        bit over;
        int placed;
        int plain_cycles;
        int fast_cycles;
        int plain_rows;
        int fast_rows;
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_stop      = 1'b0;
        i_key       = 8'h00;
        cycle_cnt   = 0;
        error_count = 0;
        exp_rows    = 3'd0;
        exp_score   = '0;
        prev_state  = ST_IDLE;
        void'($urandom(7353));
        for (int k = 0; k < 7; k++) begin
            m_seq[k] = shape_t'(6 - k);
        end
        m_cnt  = 0;
        m_cur  = 3'd0;
        m_hold = 3'd7;
        repeat (16) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;

        // idle after reset, keys alone do nothing
        check_state(o_state, ST_IDLE);
        check_rows(o_delete, 3'd0);
        check_score(o_score, '0);
        if (o_finish) begin
            report_mismatch("finish high after reset");
        end
        i_key = `KEY_DOWN;
        repeat (4) step();
        i_key = `KEY_HOLD;
        repeat (4) step();
        i_key = 8'h00;
        step();
        check_state(o_state, ST_IDLE);

        // steered pieces, rows and score
        start_game();
        repeat (14) begin
            place_piece(choose_column(m_cur), over);
        end

        // hold pulls the next shape, a second press swaps back
        hold_model();
        press(`KEY_HOLD, ST_STALL);
        press(`KEY_HOLD, ST_STALL);
        hold_model();
        place_piece(SPAWN, over);

        // plain gravity, then gravity with the speed key, compared per row
        fall_piece(8'h00, plain_cycles, plain_rows, over);
        fall_piece(`KEY_SPEED, fast_cycles, fast_rows, over);
        if (fast_cycles * plain_rows >= plain_cycles * fast_rows) begin
            report_mismatch($sformatf("speed fall took %0d cycles for %0d rows, plain fall %0d for %0d",
                fast_cycles, fast_rows, plain_cycles, plain_rows));
        end

        // stack at the spawn column until the game ends
        placed = 0;
        over   = 1'b0;
        while (!over) begin
            place_piece(SPAWN, over);
            placed++;
            if (placed > 25 && !over) begin
                report_mismatch("no game over after 25 pieces");
            end
        end
        step();
        check_state(o_state, ST_IDLE);

        // stop during play
        start_game();
        i_stop = 1'b1;
        step();
        i_stop = 1'b0;
        check_state(o_state, ST_IDLE);
        repeat (4) step();

        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/key_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tetris_defines.svh"

module key_decoder (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic [7:0]           i_key,
    input  logic                 i_start,
    input  logic                 i_stop,
    output tetris_pkg::key_cmd_t o_cmd
);
    import tetris_pkg::*;

    key_cmd_t key_d;
    key_cmd_t key_q;

    always_comb begin
        key_d = '0;
        case (i_key)
            `KEY_UP:    key_d.rotate = 1'b1;
            `KEY_DOWN:  key_d.drop   = 1'b1;
            `KEY_RIGHT: key_d.right  = 1'b1;
            `KEY_LEFT:  key_d.left   = 1'b1;
            `KEY_HOLD:  key_d.hold   = 1'b1;
            `KEY_SPEED: key_d.speed  = 1'b1;
            `KEY_ESC:   key_d.stop   = 1'b1;
            default:    key_d        = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            key_q <= '0;
        end else begin
            key_q <= key_d;
        end
    end

    // start and stop must act on the very next edge
    always_comb begin
        o_cmd       = key_q;
        o_cmd.start = i_start;
        o_cmd.stop  = key_q.stop | i_stop;
    end

endmodule

`default_nettype wire

// ==== verilog/piece_control.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tetris_defines.svh"

module piece_control (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  tetris_pkg::key_cmd_t    i_cmd,
    input  logic                    i_scan_done,
    piece_if.ctrl                   pif,
    output logic                    o_lock_req,
    output tetris_pkg::game_state_e o_state,
    output logic                    o_finish
);
    import tetris_pkg::*;

    localparam int   STALL_W = $clog2(`STALL_CYCLES + 1);
    localparam int   FALL_W  = $clog2(`FALL_LIMIT + 5);
    localparam col_t SPAWN_X = col_t'(`SPAWN_COL);

    game_state_e        state;
    logic [STALL_W-1:0] stall_cnt;
    logic [FALL_W-1:0]  fall_cnt;
    shape_t [6:0]       seq;
    shape_t [6:0]       seq_adv;
    logic [2:0]         seq_cnt;
    logic [2:0]         seq_cnt_adv;
    shape_t             hold_shape;
    logic               fall_due;
    logic               stall_done;

    assign o_state    = state;
    assign o_lock_req = (state == ST_LAND) && (pif.y == pif.ghost_y);
    assign fall_due   = fall_cnt >= FALL_W'(`FALL_LIMIT);
    // stall also waits for the landing row to settle
    assign stall_done = (stall_cnt == STALL_W'(`STALL_CYCLES - 1)) && !pif.ghost_down_ok;

    // shift register of the seven shapes, reordered after a full pass
    always_comb begin
        if (seq_cnt == 3'd6) begin
            seq_adv     = {seq[3], seq[1], seq[2], seq[6], seq[0], seq[4], seq[5]};
            seq_cnt_adv = 3'd0;
        end else begin
            seq_adv     = {seq[5:0], seq[6]};
            seq_cnt_adv = seq_cnt + 3'd1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stall_cnt <= '0;
        end else if (state != ST_STALL) begin
            stall_cnt <= '0;
        end else if (stall_cnt != STALL_W'(`STALL_CYCLES - 1)) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // gravity, five times faster with the speed key
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fall_cnt <= '0;
        end else if (state == ST_LAND || state == ST_IDLE) begin
            fall_cnt <= '0;
        end else if (!fall_due) begin
            fall_cnt <= fall_cnt + (i_cmd.speed ? FALL_W'(5) : FALL_W'(1));
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            seq         <= {3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6};
            seq_cnt     <= 3'd0;
            hold_shape  <= 3'd7;
            pif.shape   <= 3'd0;
            pif.dir     <= 2'd0;
            pif.x       <= SPAWN_X;
            pif.y       <= '0;
            pif.ghost_y <= '0;
            o_finish    <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            if (i_cmd.stop) begin
                state <= ST_IDLE;
            end else if (i_cmd.start) begin
                // start restarts from any state
                state       <= ST_STALL;
                seq_cnt     <= 3'd0;
                hold_shape  <= 3'd7;
                pif.dir     <= 2'd0;
                pif.x       <= SPAWN_X;
                pif.y       <= '0;
                pif.ghost_y <= '0;
            end else begin
                case (state)
                    ST_WAIT: begin
                        if (i_cmd.rotate) begin
                            pif.dir     <= pif.dir + 1'b1;
                            pif.ghost_y <= pif.y;
                            state       <= ST_EVAL;
                        end else if (i_cmd.drop) begin
                            pif.y <= pif.ghost_y;
                            state <= ST_LAND;
                        end else if (i_cmd.right && pif.right_ok) begin
                            pif.x       <= pif.x + 1'b1;
                            pif.ghost_y <= pif.y;
                            state       <= ST_STALL;
                        end else if (i_cmd.left && pif.left_ok) begin
                            pif.x       <= pif.x - 1'b1;
                            pif.ghost_y <= pif.y;
                            state       <= ST_STALL;
                        end else if (i_cmd.hold) begin
                            // empty slot pulls the next shape, else swap
                            if (hold_shape == 3'd7) begin
                                pif.shape <= seq_adv[6];
                                seq       <= seq_adv;
                                seq_cnt   <= seq_cnt_adv;
                            end else begin
                                pif.shape <= hold_shape;
                            end
                            hold_shape  <= pif.shape;
                            pif.dir     <= 2'd0;
                            pif.x       <= SPAWN_X;
                            pif.y       <= '0;
                            pif.ghost_y <= '0;
                            state       <= ST_STALL;
                        end else if (fall_due) begin
                            state <= ST_LAND;
                        end
                    end
                    ST_EVAL: begin
                        if (!pif.fit_ok) begin
                            pif.dir <= pif.dir - 1'b1;
                        end
                        state <= ST_STALL;
                    end
                    ST_STALL: begin
                        if (pif.ghost_down_ok) begin
                            pif.ghost_y <= pif.ghost_y + 1'b1;
                        end
                        if (stall_done) begin
                            if (pif.ghost_y == '0) begin
                                state    <= ST_IDLE;
                                o_finish <= 1'b1;
                            end else begin
                                state <= fall_due ? ST_LAND : ST_WAIT;
                            end
                        end
                    end
                    ST_LAND: begin
                        if (pif.y == pif.ghost_y) begin
                            state <= ST_DELETE;
                        end else begin
                            pif.y <= pif.y + 1'b1;
                            state <= ST_WAIT;
                        end
                    end
                    ST_DELETE: begin
                        if (i_scan_done) begin
                            pif.shape   <= seq_adv[6];
                            seq         <= seq_adv;
                            seq_cnt     <= seq_cnt_adv;
                            pif.dir     <= 2'd0;
                            pif.x       <= SPAWN_X;
                            pif.y       <= '0;
                            pif.ghost_y <= '0;
                            state       <= ST_STALL;
                        end
                    end
                    ST_IDLE: state <= ST_IDLE;
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // a piece only locks where it rests on the stack or the floor
    a_lock_landed: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_lock_req |-> !pif.ghost_down_ok);

endmodule

`default_nettype wire

// ==== verilog/piece_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface piece_if;
    import tetris_pkg::*;

    col_t   x;
    row_t   y;
    shape_t shape;
    dir_t   dir;
    row_t   ghost_y;
    logic   left_ok;
    logic   right_ok;
    logic   fit_ok;
    logic   ghost_down_ok;

    modport ctrl (
        output x, y, shape, dir, ghost_y,
        input  left_ok, right_ok, fit_ok, ghost_down_ok
    );

    modport board (
        input  x, y, shape, dir, ghost_y,
        output left_ok, right_ok, fit_ok, ghost_down_ok
    );

endinterface

`default_nettype wire

// ==== verilog/playfield.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tetris_defines.svh"

module playfield (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_clear,
    input  logic       i_lock_req,
    piece_if.board     pif,
    output logic       o_scan_done,
    output logic [2:0] o_rows_cleared
);
    import tetris_pkg::*;

    localparam row_t LAST_ROW = row_t'(`BOARD_ROWS - 1);

    cell_t        board [`BOARD_COLS][`BOARD_ROWS];
    piece_cells_t cur;
    piece_cells_t ghost;
    logic         scanning;
    row_t         scan_row;
    logic [2:0]   found;
    logic         row_full;

    // inside the board and empty
    function automatic logic cell_free(col_t c, row_t r);
        return (c < `BOARD_COLS) && (r < `BOARD_ROWS) && (board[c][r] == '0);
    endfunction

    assign cur   = shape_cells(pif.x, pif.y, pif.shape, pif.dir);
    assign ghost = shape_cells(pif.x, pif.ghost_y, pif.shape, pif.dir);

    always_comb begin
        pif.fit_ok        = 1'b1;
        pif.left_ok       = 1'b1;
        pif.right_ok      = 1'b1;
        pif.ghost_down_ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            pif.fit_ok        &= cell_free(cur[k].col, cur[k].row);
            pif.left_ok       &= cell_free(cur[k].col - 1'b1, cur[k].row);
            pif.right_ok      &= cell_free(cur[k].col + 1'b1, cur[k].row);
            pif.ghost_down_ok &= cell_free(ghost[k].col, ghost[k].row + 1'b1);
        end
    end

    always_comb begin
        row_full = 1'b1;
        for (int c = 0; c < `BOARD_COLS; c++) begin
            row_full &= (board[c][scan_row] != '0);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            for (int c = 0; c < `BOARD_COLS; c++) begin
                for (int r = 0; r < `BOARD_ROWS; r++) begin
                    board[c][r] <= '0;
                end
            end
        end else if (i_lock_req) begin
            for (int k = 0; k < 4; k++) begin
                board[cur[k].col][cur[k].row] <= cell_t'(pif.shape) + 3'd1;
            end
        end else if (scanning && row_full) begin
            // drop everything above the full row by one
            for (int c = 0; c < `BOARD_COLS; c++) begin
                for (int r = 0; r < `BOARD_ROWS; r++) begin
                    if (r == 0) begin
                        board[c][r] <= '0;
                    end else if (r <= int'(scan_row)) begin
                        board[c][r] <= board[c][r - 1];
                    end
                end
            end
        end
    end

    // one row per cycle, top to bottom
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scanning <= 1'b0;
            scan_row <= '0;
            found    <= 3'd0;
        end else if (i_clear) begin
            scanning <= 1'b0;
            scan_row <= '0;
        end else if (i_lock_req) begin
            scanning <= 1'b1;
            scan_row <= '0;
            found    <= 3'd0;
        end else if (scanning) begin
            found <= found + {2'b00, row_full};
            if (scan_row == LAST_ROW) begin
                scanning <= 1'b0;
                scan_row <= '0;
            end else begin
                scan_row <= scan_row + 1'b1;
            end
        end
    end

    // last row result counts in the same cycle as done
    assign o_scan_done    = scanning && (scan_row == LAST_ROW);
    assign o_rows_cleared = found + {2'b00, row_full};

    a_rows_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_scan_done |-> (o_rows_cleared <= 3'd4));

endmodule

`default_nettype wire

// ==== verilog/score_keeper.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "tetris_defines.svh"

module score_keeper (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_clear,
    input  logic               i_scan_done,
    input  logic [2:0]         i_rows_cleared,
    output logic [2:0]         o_delete,
    output tetris_pkg::score_t o_score
);
    import tetris_pkg::*;

    score_t step;

    always_comb begin
        case (i_rows_cleared)
            3'd1:    step = score_t'(`SCORE_1);
            3'd2:    step = score_t'(`SCORE_2);
            3'd3:    step = score_t'(`SCORE_3);
            3'd4:    step = score_t'(`SCORE_4);
            default: step = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_delete <= 3'd0;
            o_score  <= '0;
        end else begin
            // row count shows for one cycle only
            o_delete <= i_scan_done ? i_rows_cleared : 3'd0;
            if (i_clear) begin
                o_score <= '0;
            end else if (i_scan_done) begin
                o_score <= o_score + step;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tetris_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tetris_core (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic                    i_stop,
    input  logic [7:0]              i_key,
    output tetris_pkg::game_state_e o_state,
    output logic [2:0]              o_delete,
    output logic                    o_finish,
    output tetris_pkg::score_t      o_score
);
    import tetris_pkg::*;

    key_cmd_t   cmd;
    logic       lock_req;
    logic       scan_done;
    logic [2:0] rows_cleared;

    piece_if pif ();

    key_decoder key_decoder_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_key   (i_key),
        .i_start (i_start),
        .i_stop  (i_stop),
        .o_cmd   (cmd)
    );

    piece_control piece_control_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd       (cmd),
        .i_scan_done (scan_done),
        .pif         (pif),
        .o_lock_req  (lock_req),
        .o_state     (o_state),
        .o_finish    (o_finish)
    );

    playfield playfield_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_clear        (cmd.start),
        .i_lock_req     (lock_req),
        .pif            (pif),
        .o_scan_done    (scan_done),
        .o_rows_cleared (rows_cleared)
    );

    score_keeper score_keeper_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_clear        (cmd.start),
        .i_scan_done    (scan_done),
        .i_rows_cleared (rows_cleared),
        .o_delete       (o_delete),
        .o_score        (o_score)
    );

endmodule

`default_nettype wire

// ==== verilog/tetris_defines.svh ====
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// board size in cells
`define BOARD_COLS 10
`define BOARD_ROWS 20
`define SPAWN_COL 4

// settle time after every move
`define STALL_CYCLES 16
// gravity period in fall counter units
`define FALL_LIMIT 64

// keyboard scan codes
`define KEY_UP    8'h1d
`define KEY_DOWN  8'h14
`define KEY_RIGHT 8'h23
`define KEY_LEFT  8'h1c
`define KEY_SPEED 8'h1b
`define KEY_HOLD  8'h12
`define KEY_ESC   8'h76

// score added per scan, by number of rows deleted
`define SCORE_1 1
`define SCORE_2 3
`define SCORE_3 5
`define SCORE_4 7

`endif

// ==== verilog/tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

    typedef logic [3:0] col_t;
    typedef logic [4:0] row_t;
    // 0..6 are shapes, 7 marks an empty hold slot
    typedef logic [2:0] shape_t;
    typedef logic [1:0] dir_t;
    // 0 is empty, else shape + 1
    typedef logic [2:0] cell_t;
    typedef logic [9:0] score_t;

    typedef struct packed {
        col_t col;
        row_t row;
    } cell_pos_t;

    // index 0 holds the centre
    typedef cell_pos_t [3:0] piece_cells_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT,
        ST_EVAL,
        ST_STALL,
        ST_LAND,
        ST_DELETE
    } game_state_e;

    typedef struct packed {
        logic rotate;
        logic drop;
        logic right;
        logic left;
        logic hold;
        logic speed;
        logic start;
        logic stop;
    } key_cmd_t;

    function automatic piece_cells_t shape_cells(col_t cx, row_t cy, shape_t shape, dir_t dir);
        int           ofs [3][2];
        int           tmp;
        piece_cells_t cells;
        // offsets of the three outer cells for I O T S Z J L
        case (shape)
            3'd0:    ofs = '{'{-1, 0}, '{1, 0}, '{2, 0}};
            3'd1:    ofs = '{'{1, 0}, '{0, 1}, '{1, 1}};
            3'd2:    ofs = '{'{-1, 0}, '{1, 0}, '{0, 1}};
            3'd3:    ofs = '{'{1, 0}, '{-1, 1}, '{0, 1}};
            3'd4:    ofs = '{'{-1, 0}, '{0, 1}, '{1, 1}};
            3'd5:    ofs = '{'{-1, 0}, '{1, 0}, '{1, 1}};
            default: ofs = '{'{-1, 0}, '{1, 0}, '{-1, 1}};
        endcase
        // quarter turn clockwise per direction step
        for (int r = 0; r < 3; r++) begin
            if (r < int'(dir)) begin
                for (int k = 0; k < 3; k++) begin
                    tmp = ofs[k][0];
                    ofs[k][0] = -ofs[k][1];
                    ofs[k][1] = tmp;
                end
            end
        end
        cells[0].col = cx;
        cells[0].row = cy;
        // negative results wrap out of the board and fail the range checks
        for (int k = 0; k < 3; k++) begin
            cells[k + 1].col = col_t'(int'(cx) + ofs[k][0]);
            cells[k + 1].row = row_t'(int'(cy) + ofs[k][1]);
        end
        return cells;
    endfunction

endpackage

`default_nettype wire
